//--- Makefile
# Verilator flow for the FM register interface testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_fm_mmr -f sim.f -Mdir obj_dir -o sim_fm_mmr

run: compile
	./obj_dir/sim_fm_mmr > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- fm_bus_pkg.sv
// ############################
// host bus side definitions
// register numbers follow the usual FM chip map, CSM/DAC/test left out
// upd_cmd_t is valid only in a cycle with a group or keyon bit set
// ############################
package fm_bus_pkg;

    // global register numbers
    localparam logic [7:0] REG_LFO    = 8'h22;
    localparam logic [7:0] REG_CLKA1  = 8'h24; // timer A bits 9:2
    localparam logic [7:0] REG_CLKA2  = 8'h25; // timer A bits 1:0
    localparam logic [7:0] REG_CLKB   = 8'h26;
    localparam logic [7:0] REG_TIMER  = 8'h27;
    localparam logic [7:0] REG_KON    = 8'h28;
    localparam logic [7:0] REG_CLK_N6 = 8'h2D;
    localparam logic [7:0] REG_CLK_N3 = 8'h2E;
    localparam logic [7:0] REG_CLK_N2 = 8'h2F;

    typedef struct packed {
        logic       lfo_en;
        logic [2:0] lfo_freq;
        logic [9:0] timer_a;
        logic [7:0] timer_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;    // pulse
        logic       clr_b;    // pulse
    } glb_regs_t;

    // one parameter update, built from a single data write
    typedef struct packed {
        logic [6:0] op_grp;   // one-hot, 0x3X .. 0x9X
        logic [2:0] ch_grp;   // one-hot, fnum low / fb-alg / pan-ams-pms
        logic       keyon;
        logic [2:0] ch;       // 0..5
        logic [1:0] op;
        logic [5:0] fhi;      // block and fnum high, from the shared latch
        logic [7:0] data;
    } upd_cmd_t;

endpackage

//--- fm_clk_div.sv
// ############################
// synthesis clock enable, one clk wide
// divides by 6, 3 or 2 while cen is high
// a new divider setting restarts the count
// ############################
`timescale 1ns/1ps

module fm_clk_div (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [1:0] div_sel,
    output logic       clk_en
);

    logic [2:0] cnt;
    logic [1:0] sel_q;
    logic [2:0] last;   // terminal count, N-1

    always_comb begin
        case (sel_q)
            2'b10:   last = 3'd5;
            2'b11:   last = 3'd2;
            default: last = 3'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            sel_q  <= 2'b10;
            clk_en <= 1'b0;
        end else begin
            sel_q  <= div_sel;
            clk_en <= 1'b0;
            if (div_sel != sel_q) begin
                cnt <= '0; // reload on new setting
            end else if (cen) begin
                clk_en <= (cnt == last);
                cnt    <= (cnt == last) ? 3'd0 : cnt + 3'd1;
            end
        end
    end

endmodule

//--- fm_mmr_top.sv
// ############################
// FM register interface top
// port 0 latches the register, port 1 writes data
// timers are not here, only their settings leave
// ############################
`timescale 1ns/1ps

module fm_mmr_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [7:0]              din,
    input  logic                    write,
    input  logic [1:0]              addr,
    output logic                    clk_en,
    output logic                    busy,
    output fm_bus_pkg::glb_regs_t   glb,
    output fm_voice_pkg::slot_out_t slot_q,
    output logic                    slot_vld
);

    fm_bus_pkg::upd_cmd_t    upd;
    logic [1:0]              div_sel;
    logic [4:0]              op_idx;
    logic [2:0]              ch_idx;
    fm_voice_pkg::op_param_t op_rd;
    fm_voice_pkg::ch_param_t ch_rd;

    fm_reg_decode i_decode (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .din     (din),
        .write   (write),
        .addr    (addr),
        .glb     (glb),
        .upd     (upd),
        .div_sel (div_sel),
        .busy    (busy)
    );

    fm_clk_div i_clk_div (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    // operator store, index {ch, op} = ch*4 + op, byte lane per group
    fm_param_store #(
        .payload_t (fm_voice_pkg::op_param_t),
        .DEPTH     (fm_voice_pkg::NUM_SLOT)
    ) i_op_store (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (|upd.op_grp),
        .wr_idx  ({upd.ch, upd.op}),
        .wr_data (fm_voice_pkg::op_param_t'({7{upd.data}})),
        .wr_mask (fm_voice_pkg::op_param_t'({{8{upd.op_grp[6]}}, {8{upd.op_grp[5]}},
                                             {8{upd.op_grp[4]}}, {8{upd.op_grp[3]}},
                                             {8{upd.op_grp[2]}}, {8{upd.op_grp[1]}},
                                             {8{upd.op_grp[0]}}})),
        .rd_idx  (op_idx),
        .rd_data (op_rd)
    );

    // channel store, fnum low joins the high latch, keyon mask from data[7:4]
    fm_param_store #(
        .payload_t (fm_voice_pkg::ch_param_t),
        .DEPTH     (fm_voice_pkg::NUM_CH)
    ) i_ch_store (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (|upd.ch_grp | upd.keyon),
        .wr_idx  (upd.ch),
        .wr_data (fm_voice_pkg::ch_param_t'({upd.data[7:4], upd.data, upd.data,
                                             upd.fhi, upd.data})),
        .wr_mask (fm_voice_pkg::ch_param_t'({{4{upd.keyon}}, {8{upd.ch_grp[2]}},
                                             {8{upd.ch_grp[1]}}, {14{upd.ch_grp[0]}}})),
        .rd_idx  (ch_idx),
        .rd_data (ch_rd)
    );

    fm_slot_seq i_slot_seq (
        .clk      (clk),
        .rst      (rst),
        .clk_en   (clk_en),
        .op_rd    (op_rd),
        .ch_rd    (ch_rd),
        .op_idx   (op_idx),
        .ch_idx   (ch_idx),
        .slot_q   (slot_q),
        .slot_vld (slot_vld)
    );

endmodule

//--- fm_param_store.sv
// ############################
// parameter memory, DEPTH entries of payload_t
// writes merge under wr_mask, read is combinational
// rd_idx must stay below DEPTH
// ############################
`timescale 1ns/1ps

module fm_param_store #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 24
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_idx,
    input  payload_t                 wr_data,
    input  payload_t                 wr_mask,
    input  logic [$clog2(DEPTH)-1:0] rd_idx,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            // only the masked group changes
            mem[wr_idx] <= payload_t'((mem[wr_idx] & ~wr_mask) | (wr_data & wr_mask));
        end
    end

    assign rd_data = mem[rd_idx];

endmodule

//--- fm_reg_decode.sv
// ############################
// two-port byte bus decoder, one write per rising edge of write
// write must drop between bus cycles to start a new one
// 0x21, 0x29..0x2C and 0xA8..0xAE are accepted but ignored
// ############################
`timescale 1ns/1ps

module fm_reg_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clk_en,
    input  logic [7:0]            din,
    input  logic                  write,
    input  logic [1:0]            addr,
    output fm_bus_pkg::glb_regs_t glb,
    output fm_bus_pkg::upd_cmd_t  upd,
    output logic [1:0]            div_sel,
    output logic                  busy
);

    logic                 wr_q;
    logic                 wr_qq;
    logic [7:0]           din_q;
    logic [1:0]           addr_q;
    logic                 wr_go;     // first cycle of a bus write
    logic [7:0]           sel_reg;   // latched register number
    logic                 bank;      // upper channel bank
    logic [5:0]           fhi;       // shared block/fnum high latch
    logic [4:0]           busy_cnt;
    fm_bus_pkg::upd_cmd_t nxt;

    // input stage
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q  <= 1'b0;
            wr_qq <= 1'b0;
        end else begin
            wr_q  <= write;
            wr_qq <= wr_q;
        end
    end

    always_ff @(posedge clk) begin
        din_q  <= din;
        addr_q <= addr;
    end

    assign wr_go = wr_q & ~wr_qq;

    always_comb begin
        nxt      = '0;
        nxt.ch   = bank ? 3'(sel_reg[1:0]) + 3'd3 : 3'(sel_reg[1:0]);
        nxt.op   = sel_reg[3:2];
        nxt.fhi  = fhi;
        nxt.data = din_q;
        if (sel_reg[1:0] != 2'b11) begin
            casez (sel_reg)
                8'hA0, 8'hA1, 8'hA2: nxt.ch_grp = 3'b001; // fnum low
                8'hB0, 8'hB1, 8'hB2: nxt.ch_grp = 3'b010; // fb/alg
                8'hB4, 8'hB5, 8'hB6: nxt.ch_grp = 3'b100; // pan/ams/pms
                8'h3?, 8'h4?, 8'h5?, 8'h6?, 8'h7?, 8'h8?, 8'h9?:
                    nxt.op_grp = 7'd1 << (sel_reg[7:4] - 4'd3);
                fm_bus_pkg::REG_KON: begin
                    // channel code 3 and 7 select nothing
                    if (din_q[1:0] != 2'b11) begin
                        nxt.keyon = 1'b1;
                        nxt.ch    = din_q[2] ? 3'(din_q[1:0]) + 3'd3 : 3'(din_q[1:0]);
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            bank    <= 1'b0;
            fhi     <= '0;
            glb     <= '0;
            upd     <= '0;
            div_sel <= 2'b10; // divide by 6
        end else begin
            upd <= '0;
            if (wr_go) begin
                if (!addr_q[0]) begin
                    sel_reg <= din_q;
                    bank    <= addr_q[1];
                end else begin
                    upd <= nxt;
                    case (sel_reg)
                        fm_bus_pkg::REG_LFO:    {glb.lfo_en, glb.lfo_freq} <= din_q[3:0];
                        fm_bus_pkg::REG_CLKA1:  glb.timer_a[9:2] <= din_q;
                        fm_bus_pkg::REG_CLKA2:  glb.timer_a[1:0] <= din_q[1:0];
                        fm_bus_pkg::REG_CLKB:   glb.timer_b <= din_q;
                        fm_bus_pkg::REG_TIMER: begin
                            {glb.clr_b, glb.clr_a, glb.irq_en_b, glb.irq_en_a,
                             glb.load_b, glb.load_a} <= din_q[5:0];
                        end
                        fm_bus_pkg::REG_CLK_N6: div_sel[1] <= 1'b1;
                        fm_bus_pkg::REG_CLK_N3: div_sel[0] <= 1'b1;
                        fm_bus_pkg::REG_CLK_N2: div_sel <= 2'b00;
                        8'hA4, 8'hA5, 8'hA6:    fhi <= din_q[5:0]; // one latch for all channels
                        default: ;
                    endcase
                end
            end else if (clk_en) begin
                glb.clr_a <= 1'b0;
                glb.clr_b <= 1'b0;
            end
        end
    end

    // busy for 32 synthesis clock enables after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (wr_go && addr_q[0]) begin
            busy     <= 1'b1;
            busy_cnt <= '0; // restart
        end else if (clk_en && busy) begin
            busy_cnt <= busy_cnt + 5'd1;
            if (busy_cnt == 5'd31) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- fm_slot_seq.sv
// ############################
// slot sequencer, one operator slot per clock enable
// slot order is channel major, slot = ch*4 + op
// slot_vld follows clk_en by one clk
// ############################
`timescale 1ns/1ps

module fm_slot_seq (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clk_en,
    input  fm_voice_pkg::op_param_t op_rd,
    input  fm_voice_pkg::ch_param_t ch_rd,
    output logic [4:0]              op_idx,
    output logic [2:0]              ch_idx,
    output fm_voice_pkg::slot_out_t slot_q,
    output logic                    slot_vld
);

    logic [4:0] slot;
    logic [2:0] ch;
    logic [1:0] op;

    assign ch = 3'(slot / fm_voice_pkg::NUM_OP);
    assign op = 2'(slot % fm_voice_pkg::NUM_OP);

    // store read addresses
    assign op_idx = slot;
    assign ch_idx = ch;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot     <= '0;
            slot_vld <= 1'b0;
        end else begin
            slot_vld <= clk_en;
            if (clk_en) begin
                slot <= (slot == 5'(fm_voice_pkg::NUM_SLOT - 1)) ? 5'd0 : slot + 5'd1;
            end
        end
    end

    // capture the slot that is being left
    always_ff @(posedge clk) begin
        if (clk_en) begin
            slot_q.slot   <= slot;
            slot_q.ch     <= ch;
            slot_q.op     <= op;
            slot_q.op_prm <= op_rd;
            slot_q.ch_prm <= ch_rd;
        end
    end

endmodule

//--- fm_voice_pkg.sv
// ############################
// voice side definitions
// operator bytes are kept exactly as written, no field decoding here
// byte i of op_param_t belongs to register group 0x30 + 0x10*i
// ############################
package fm_voice_pkg;

    localparam int NUM_CH   = 6;
    localparam int NUM_OP   = 4;
    localparam int NUM_SLOT = 24;

    // lowest byte first in register order, so the one-hot group maps to a byte lane
    typedef struct packed {
        logic [7:0] ssg_eg;    // 0x9X
        logic [7:0] sl_rr;     // 0x8X
        logic [7:0] d2r;       // 0x7X
        logic [7:0] amen_d1r;  // 0x6X
        logic [7:0] ks_ar;     // 0x5X
        logic [7:0] tl;        // 0x4X
        logic [7:0] dt1_mul;   // 0x3X
    } op_param_t;

    typedef struct packed {
        logic [3:0]  keyon;        // operator mask from 0x28
        logic [7:0]  pan_ams_pms;  // 0xB4..0xB6
        logic [7:0]  fb_alg;       // 0xB0..0xB2
        logic [2:0]  block;
        logic [10:0] fnum;
    } ch_param_t;

    typedef struct packed {
        logic [4:0] slot;
        logic [2:0] ch;
        logic [1:0] op;
        op_param_t  op_prm;
        ch_param_t  ch_prm;
    } slot_out_t;

endpackage

//--- sim.f
fm_bus_pkg.sv
fm_voice_pkg.sv
fm_clk_div.sv
fm_reg_decode.sv
fm_param_store.sv
fm_slot_seq.sv
fm_mmr_top.sv
tb_clk_gen.sv
tb_fm_mmr.sv

//--- tb_clk_gen.sv
// ##############################
// testbench clock and reset
// rst is released on a falling edge after RST_CYCLES rising edges
// ##############################
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tb_fm_mmr.sv
// ##############################
// testbench for fm_mmr_top with cen held high the whole run
// random register writes from a fixed xorshift seed against a model
// global registers are only written on bank 0
// ##############################
`timescale 1ns/1ps

module tb_fm_mmr;

    localparam int NUM_WR  = 200;
    localparam int TIMEOUT = NUM_WR * 2 * 300;

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic [7:0]              din;
    logic                    write;
    logic [1:0]              addr;
    logic                    clk_en;
    logic                    busy;
    fm_bus_pkg::glb_regs_t   glb;
    fm_voice_pkg::slot_out_t slot_q;
    logic                    slot_vld;

    // reference model
    fm_voice_pkg::op_param_t op_m [24];
    fm_voice_pkg::ch_param_t ch_m [6];
    fm_bus_pkg::glb_regs_t   glb_m;
    logic [5:0]              fhi_m;   // shared block/fnum high latch
    logic [1:0]              div_m;

    logic [31:0] rng;
    logic [7:0]  glb_list [5];
    int          errors;
    int          checks;
    int          cycles;

    tb_clk_gen #(.PERIOD(40), .RST_CYCLES(2)) i_clk_gen (.clk(clk), .rst(rst));

    fm_mmr_top i_fm_mmr_top (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .din      (din),
        .write    (write),
        .addr     (addr),
        .clk_en   (clk_en),
        .busy     (busy),
        .glb      (glb),
        .slot_q   (slot_q),
        .slot_vld (slot_vld)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int div_ratio(input logic [1:0] sel);
        case (sel)
            2'b10:   return 6;
            2'b11:   return 3;
            default: return 2;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic bus_cycle(input logic [1:0] a, input logic [7:0] d);
        @(negedge clk);
        write = 1'b1;
        addr  = a;
        din   = d;
        @(negedge clk);
        write = 1'b0; // write must drop between bus cycles
    endtask

    task automatic model_write(input logic bank, input logic [7:0] r, input logic [7:0] d);
        logic [2:0] c;
        logic [4:0] idx;
        int         grp;
        c   = 3'(3 * int'(bank) + int'(r[1:0]));
        idx = 5'(c) * 5'd4 + 5'(r[3:2]);
        grp = int'(r[7:4]) - 3;
        if (r >= 8'h30 && r <= 8'h9F && r[1:0] != 2'b11) begin
            op_m[idx] = (op_m[idx] & ~(56'hFF << (8 * grp))) | (56'(d) << (8 * grp));
        end else if (r >= 8'hA0 && r <= 8'hA2) begin
            ch_m[c].fnum  = {fhi_m[2:0], d};
            ch_m[c].block = fhi_m[5:3];
        end else if (r >= 8'hA4 && r <= 8'hA6) begin
            fhi_m = d[5:0];
        end else if (r >= 8'hB0 && r <= 8'hB2) begin
            ch_m[c].fb_alg = d;
        end else if (r >= 8'hB4 && r <= 8'hB6) begin
            ch_m[c].pan_ams_pms = d;
        end else if (r == 8'h28 && d[2:0] != 3'd3 && d[2:0] != 3'd7) begin
            c = (d[2:0] > 3'd3) ? d[2:0] - 3'd1 : d[2:0]; // codes 4..6 are channels 3..5
            ch_m[c].keyon = d[7:4];
        end
        case (r)
            8'h22: {glb_m.lfo_en, glb_m.lfo_freq} = d[3:0];
            8'h24: glb_m.timer_a[9:2] = d;
            8'h25: glb_m.timer_a[1:0] = d[1:0];
            8'h26: glb_m.timer_b = d;
            8'h27: begin
                glb_m.load_a   = d[0];
                glb_m.load_b   = d[1];
                glb_m.irq_en_a = d[2];
                glb_m.irq_en_b = d[3];
                glb_m.clr_a    = d[4];
                glb_m.clr_b    = d[5];
            end
            8'h2D: div_m[1] = 1'b1;
            8'h2E: div_m[0] = 1'b1;
            8'h2F: div_m = 2'b00;
            default: ;
        endcase
    endtask

    // returns one clk after the data cycle when glb has taken the write
    task automatic write_reg(input logic bank, input logic [7:0] r, input logic [7:0] d);
        bus_cycle({bank, 1'b0}, r);
        bus_cycle({bank, 1'b1}, d);
        @(negedge clk);
        model_write(bank, r, d);
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic check_rotation();
        int         seen;
        int         exp_slot;
        logic       en_prev;
        logic [4:0] s;
        seen     = 0;
        exp_slot = -1;
        @(negedge clk);
        en_prev = clk_en;
        while (seen < 24) begin
            @(negedge clk);
            if (slot_vld !== en_prev) begin
                report_mismatch("slot_vld", 64'(slot_vld), 64'(en_prev));
            end
            en_prev = clk_en;
            if (slot_vld) begin
                seen++;
                checks++;
                s = slot_q.slot;
                if (s > 5'd23) begin
                    $display("** Error: slot number %0d is out of range at %0t", s, $time);
                    errors++;
                end else begin
                    if (exp_slot >= 0 && int'(s) != exp_slot) begin
                        report_mismatch("slot_q.slot", 64'(s), 64'(exp_slot));
                    end
                    exp_slot = (int'(s) + 1) % 24;
                    if (int'(slot_q.ch) != int'(s) / 4 || int'(slot_q.op) != int'(s) % 4) begin
                        report_mismatch("slot_q.ch/op", 64'({slot_q.ch, slot_q.op}), 64'(s));
                    end
                    if (slot_q.op_prm !== op_m[s]) begin
                        report_mismatch("slot_q.op_prm", 64'(slot_q.op_prm), 64'(op_m[s]));
                    end
                    if (slot_q.ch_prm !== ch_m[3'(s / 5'd4)]) begin
                        report_mismatch("slot_q.ch_prm", 64'(slot_q.ch_prm),
                                        64'(ch_m[3'(s / 5'd4)]));
                    end
                end
            end
        end
    endtask

    task automatic check_glb();
        if (glb !== glb_m) begin
            report_mismatch("glb", 64'(glb), 64'(glb_m));
        end
        checks++;
    endtask

    // timer clear pulses end at the next synthesis enable
    task automatic check_clr_gone();
        while (!clk_en) @(negedge clk);
        @(negedge clk);
        if (glb.clr_a !== 1'b0 || glb.clr_b !== 1'b0) begin
            report_mismatch("glb.clr_a/clr_b", 64'({glb.clr_a, glb.clr_b}), 64'(0));
        end
        checks++;
        glb_m.clr_a = 1'b0;
        glb_m.clr_b = 1'b0;
    endtask

    task automatic check_spacing();
        int gap;
        int n;
        n = div_ratio(div_m);
        repeat (2) begin // settle on the new ratio
            @(negedge clk);
            while (!clk_en) @(negedge clk);
        end
        repeat (3) begin
            gap = 1;
            @(negedge clk);
            while (!clk_en) begin
                @(negedge clk);
                gap++;
            end
            if (gap != n) begin
                report_mismatch("clk_en spacing", 64'(gap), 64'(n));
            end
            checks++;
        end
    endtask

    task automatic check_busy();
        int n;
        int cnt;
        n = div_ratio(div_m);
        wait_idle();
        bus_cycle(2'b00, 8'h22); // address only
        repeat (4) begin
            @(negedge clk);
            if (busy !== 1'b0) begin
                report_mismatch("busy", 64'(busy), 64'(0));
            end
        end
        rng = xorshift32(rng);
        bus_cycle(2'b01, rng[7:0]);
        @(negedge clk);
        model_write(1'b0, 8'h22, rng[7:0]);
        if (busy !== 1'b1) begin
            report_mismatch("busy", 64'(busy), 64'(1));
        end
        cnt = 0;
        while (busy && cnt <= 32 * n + 2) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt > 32 * n + 2 || cnt < 31 * n) begin
            $display("busy lasted %0d cycles, allowed %0d to %0d", cnt, 31 * n, 32 * n + 2);
            errors++;
        end
        checks += 2;
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("checks: %0d errors: %0d", checks, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [7:0] r;
        logic       bank;
        int         kind;
        int         lo;
        cen      = 1'b1;
        din      = '0;
        write    = 1'b0;
        addr     = '0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        rng      = 32'h93920732;
        glb_m    = '0;
        fhi_m    = '0;
        div_m    = 2'b10;
        glb_list = '{8'h22, 8'h24, 8'h25, 8'h26, 8'h27};
        for (int i = 0; i < 24; i++) begin
            op_m[i] = '0;
        end
        for (int i = 0; i < 6; i++) begin
            ch_m[i] = '0;
        end

        while (rst !== 1'b0) @(posedge clk);
        @(negedge clk);
        if (busy !== 1'b0 || slot_vld !== 1'b0 || clk_en !== 1'b0) begin
            $display("outputs not inactive after reset at %0t", $time);
            errors++;
        end
        check_glb();
        while (!slot_vld) @(negedge clk);
        if (slot_q.slot !== 5'd0) begin
            report_mismatch("slot_q.slot", 64'(slot_q.slot), 64'(0));
        end

        // operator parameters
        repeat (100) begin
            rng  = xorshift32(rng);
            r    = 8'(32'h30 + rng[31:16] % 32'd112);
            bank = rng[8];
            write_reg(bank, r, rng[7:0]);
        end
        wait_idle();
        check_rotation();

        // channel parameters and key-on
        repeat (60) begin
            rng  = xorshift32(rng);
            kind = int'(rng[1:0]);
            lo   = int'(rng[3:2]);
            bank = rng[4];
            case (kind)
                0: begin
                    write_reg(bank, 8'(32'hA4 + lo % 3), rng[23:16]);
                    write_reg(bank, 8'(32'hA0 + lo), rng[15:8]);
                end
                1: write_reg(bank, 8'(32'hB0 + lo), rng[15:8]);
                2: write_reg(bank, 8'(32'hB4 + lo), rng[15:8]);
                default: write_reg(bank, 8'h28, rng[15:8]);
            endcase
        end
        wait_idle();
        check_rotation();

        // global registers
        repeat (24) begin
            rng = xorshift32(rng);
            r   = glb_list[rng[31:16] % 32'd5];
            write_reg(1'b0, r, rng[7:0]);
            check_glb();
            if (r == 8'h27) begin
                check_clr_gone();
            end
        end

        // divider ratios
        write_reg(1'b0, 8'h2F, 8'h00);
        check_spacing();
        write_reg(1'b0, 8'h2E, 8'h00);
        check_spacing();
        write_reg(1'b0, 8'h2D, 8'h00);
        check_spacing();
        write_reg(1'b0, 8'h2F, 8'h00);
        write_reg(1'b0, 8'h2D, 8'h00);
        check_spacing();

        check_busy();
        check_glb();

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
